// File: logic/axi_pkg.sv
`default_nettype none

package axi_pkg;

	localparam int DATA_W = 64;
	localparam int ID_W   = 4;
	localparam int LEN_W  = 8;   // AxLEN, beats minus one
	localparam int SIZE_W = 3;
	localparam int RESP_W = 2;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_e;

	typedef enum logic [RESP_W-1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// Same codes as AxSIZE
	typedef enum logic [1:0] {
		BYTE1 = 2'b00,
		BYTE2 = 2'b01,
		BYTE4 = 2'b10,
		BYTE8 = 2'b11
	} access_size_e;

	typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_BURST} slv_state_e;

endpackage

`default_nettype wire

// File: logic/axi_read_if.sv
`default_nettype none

interface axi_read_if #(
	parameter int ADDR_W = 32
) (
	input wire clk
);

	// AR channel
	logic                         ar_valid;
	logic                         ar_ready;
	logic [axi_pkg::ID_W-1:0]     ar_id;
	logic [ADDR_W-1:0]            ar_addr;
	logic [axi_pkg::LEN_W-1:0]    ar_len;
	logic [axi_pkg::SIZE_W-1:0]   ar_size;
	axi_pkg::burst_e              ar_burst;

	// R channel
	logic                         r_valid;
	logic                         r_ready;
	logic [axi_pkg::ID_W-1:0]     r_id;
	logic [axi_pkg::DATA_W-1:0]   r_data;
	axi_pkg::resp_e               r_resp;
	logic                         r_last;

	modport master (
		input  clk,
		output ar_valid, ar_id, ar_addr, ar_len, ar_size, ar_burst, r_ready,
		input  ar_ready, r_valid, r_id, r_data, r_resp, r_last
	);

	modport slave (
		input  clk,
		input  ar_valid, ar_id, ar_addr, ar_len, ar_size, ar_burst, r_ready,
		output ar_ready, r_valid, r_id, r_data, r_resp, r_last
	);

endinterface

`default_nettype wire

// File: logic/axi_read_master.sv
`default_nettype none

module axi_read_master #(
	parameter int ADDR_W = 32
) (
	input  wire                          clk,
	input  wire                          reset_n,

	input  wire                          cpu_req_valid_i,
	output logic                         cpu_req_ready_o,
	input  wire [axi_pkg::ID_W-1:0]      cpu_id_i,
	input  wire [ADDR_W-1:0]             cpu_addr_i,
	input  wire [axi_pkg::LEN_W-1:0]     cpu_len_i,
	input  wire axi_pkg::access_size_e   cpu_size_i,

	output logic                         cpu_r_valid_o,
	output logic [axi_pkg::DATA_W-1:0]   cpu_r_data_o,
	output axi_pkg::resp_e               cpu_r_resp_o,
	output logic [axi_pkg::ID_W-1:0]     cpu_r_id_o,
	output logic                         cpu_r_last_o,

	axi_read_if.master                   axi
);

	axi_pkg::rd_state_e state;

	// Captured request
	logic [axi_pkg::ID_W-1:0]    id_q;
	logic [ADDR_W-1:0]           addr_q;
	logic [axi_pkg::LEN_W-1:0]   len_q;
	axi_pkg::access_size_e       size_q;

	logic                        req_hs;
	logic                        ar_hs;
	logic                        r_hs;
	logic [axi_pkg::DATA_W-1:0]  lane_bits;
	logic [axi_pkg::DATA_W-1:0]  lane_mask;

	assign cpu_req_ready_o = (state == axi_pkg::RD_IDLE);
	assign req_hs = cpu_req_valid_i && cpu_req_ready_o;
	assign ar_hs  = axi.ar_valid && axi.ar_ready;
	assign r_hs   = axi.r_valid && axi.r_ready;

	// AR payload straight from the captured request
	assign axi.ar_valid = (state == axi_pkg::RD_ADDR);
	assign axi.ar_id    = id_q;
	assign axi.ar_addr  = {addr_q[ADDR_W-1:3], 3'b000};  // Word aligned
	assign axi.ar_len   = len_q;
	assign axi.ar_size  = {1'b0, size_q};
	assign axi.ar_burst = axi_pkg::INCR;
	assign axi.r_ready  = (state == axi_pkg::RD_DATA);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= axi_pkg::RD_IDLE;
		end else begin
			case (state)
				axi_pkg::RD_IDLE: begin
					if (req_hs)
						state <= axi_pkg::RD_ADDR;
				end
				axi_pkg::RD_ADDR: begin
					if (ar_hs)
						state <= axi_pkg::RD_DATA;
				end
				axi_pkg::RD_DATA: begin
					if (r_hs && axi.r_last)
						state <= axi_pkg::RD_IDLE;
				end
				default: state <= axi_pkg::RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_hs) begin
			id_q   <= cpu_id_i;
			addr_q <= cpu_addr_i;
			len_q  <= cpu_len_i;
			size_q <= cpu_size_i;
		end
	end

	// Keep only the addressed bytes, in place
	always_comb begin
		lane_bits = '0;
		case (size_q)
			axi_pkg::BYTE1: lane_bits[7:0]  = '1;
			axi_pkg::BYTE2: lane_bits[15:0] = '1;
			axi_pkg::BYTE4: lane_bits[31:0] = '1;
			default:        lane_bits       = '1;
		endcase
		lane_mask = lane_bits << {addr_q[2:0], 3'b000};
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
			cpu_r_last_o  <= 1'b0;
		end else begin
			cpu_r_valid_o <= r_hs;
			cpu_r_last_o  <= r_hs && axi.r_last;
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			cpu_r_data_o <= axi.r_data & lane_mask;
			cpu_r_resp_o <= axi.r_resp;
			cpu_r_id_o   <= axi.r_id;
		end
	end

endmodule

`default_nettype wire

// File: logic/axi_read_ram.sv
`default_nettype none

module axi_read_ram #(
	parameter int ADDR_W    = 32,
	parameter int MEM_AW    = 10,
	parameter int RESP_WAIT = 2
) (
	input  wire                          clk,
	input  wire                          reset_n,

	input  wire                          mem_we_i,
	input  wire [MEM_AW-1:0]             mem_waddr_i,
	input  wire [axi_pkg::DATA_W-1:0]    mem_wdata_i,

	axi_read_if.slave                    axi
);

	localparam int WORD_AW = ADDR_W - 3;
	localparam int WAIT_W  = (RESP_WAIT > 1) ? $clog2(RESP_WAIT) : 1;

	logic [axi_pkg::DATA_W-1:0] mem [0:(1 << MEM_AW)-1];

	axi_pkg::slv_state_e          state;
	logic [WAIT_W-1:0]            wait_cnt;
	logic [axi_pkg::LEN_W-1:0]    beat_cnt;

	logic [axi_pkg::ID_W-1:0]     id_q;
	logic [axi_pkg::LEN_W-1:0]    len_q;
	logic [WORD_AW-1:0]           word_addr;  // Current beat

	logic                         ar_hs;
	logic                         r_hs;
	logic                         in_range;

	// Backdoor fill
	always_ff @(posedge clk) begin
		if (mem_we_i)
			mem[mem_waddr_i] <= mem_wdata_i;
	end

	assign ar_hs = axi.ar_valid && axi.ar_ready;
	assign r_hs  = axi.r_valid && axi.r_ready;

	assign axi.ar_ready = (state == axi_pkg::S_IDLE);
	assign axi.r_valid  = (state == axi_pkg::S_BURST);
	assign axi.r_last   = (state == axi_pkg::S_BURST) && (beat_cnt == len_q);
	assign axi.r_id     = id_q;

	assign in_range = (word_addr >> MEM_AW) == '0;

	always_comb begin
		if (in_range) begin
			axi.r_data = mem[word_addr[MEM_AW-1:0]];
			axi.r_resp = axi_pkg::OKAY;
		end else begin
			axi.r_data = '0;
			axi.r_resp = axi_pkg::SLVERR;  // Past end of memory
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= axi_pkg::S_IDLE;
			wait_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				axi_pkg::S_IDLE: begin
					if (ar_hs) begin
						beat_cnt <= '0;
						if (RESP_WAIT == 0) begin
							state <= axi_pkg::S_BURST;
						end else begin
							wait_cnt <= WAIT_W'(RESP_WAIT - 1);
							state    <= axi_pkg::S_WAIT;
						end
					end
				end
				axi_pkg::S_WAIT: begin
					if (wait_cnt == '0)
						state <= axi_pkg::S_BURST;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				axi_pkg::S_BURST: begin
					if (r_hs) begin
						if (axi.r_last)
							state <= axi_pkg::S_IDLE;
						else
							beat_cnt <= beat_cnt + 1'b1;
					end
				end
				default: state <= axi_pkg::S_IDLE;
			endcase
		end
	end

	// Request latch and INCR stepping
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			id_q      <= axi.ar_id;
			len_q     <= axi.ar_len;
			word_addr <= axi.ar_addr[ADDR_W-1:3];
		end else if (r_hs) begin
			word_addr <= word_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/axi_read_top.sv
`default_nettype none

module axi_read_top #(
	parameter int ADDR_W    = 32,
	parameter int MEM_AW    = 10,
	parameter int RESP_WAIT = 2
) (
	input  wire                          clk,
	input  wire                          reset_n,

	// Core request port
	input  wire                          cpu_req_valid_i,
	output logic                         cpu_req_ready_o,
	input  wire [axi_pkg::ID_W-1:0]      cpu_id_i,
	input  wire [ADDR_W-1:0]             cpu_addr_i,
	input  wire [axi_pkg::LEN_W-1:0]     cpu_len_i,
	input  wire axi_pkg::access_size_e   cpu_size_i,

	// Read data back to the core, no ready
	output logic                         cpu_r_valid_o,
	output logic [axi_pkg::DATA_W-1:0]   cpu_r_data_o,
	output axi_pkg::resp_e               cpu_r_resp_o,
	output logic [axi_pkg::ID_W-1:0]     cpu_r_id_o,
	output logic                         cpu_r_last_o,

	// Fill port, idle bus only
	input  wire                          mem_we_i,
	input  wire [MEM_AW-1:0]             mem_waddr_i,
	input  wire [axi_pkg::DATA_W-1:0]    mem_wdata_i
);

	axi_read_if #(
		.ADDR_W (ADDR_W)
	) axi_bus (
		.clk (clk)
	);

	axi_read_master #(
		.ADDR_W (ADDR_W)
	) axi_read_master_inst (
		.clk             (clk),
		.reset_n         (reset_n),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_req_ready_o (cpu_req_ready_o),
		.cpu_id_i        (cpu_id_i),
		.cpu_addr_i      (cpu_addr_i),
		.cpu_len_i       (cpu_len_i),
		.cpu_size_i      (cpu_size_i),
		.cpu_r_valid_o   (cpu_r_valid_o),
		.cpu_r_data_o    (cpu_r_data_o),
		.cpu_r_resp_o    (cpu_r_resp_o),
		.cpu_r_id_o      (cpu_r_id_o),
		.cpu_r_last_o    (cpu_r_last_o),
		.axi             (axi_bus.master)
	);

	axi_read_ram #(
		.ADDR_W    (ADDR_W),
		.MEM_AW    (MEM_AW),
		.RESP_WAIT (RESP_WAIT)
	) axi_read_ram_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.mem_we_i    (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.axi         (axi_bus.slave)
	);

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int HALF_PERIOD = 5
) (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial clk_o = 1'b0;

	always #(HALF_PERIOD) clk_o = ~clk_o;  // 10 ns period

endmodule

`default_nettype wire

// File: bench/axi_read_props.sv
`default_nettype none

module axi_read_props #(
	parameter int ADDR_W = 32
) (
	input wire                       clk,
	input wire                       reset_n,
	input wire                       ar_valid_i,
	input wire                       ar_ready_i,
	input wire [axi_pkg::ID_W-1:0]   ar_id_i,
	input wire [ADDR_W-1:0]          ar_addr_i,
	input wire [axi_pkg::LEN_W-1:0]  ar_len_i,
	input wire [axi_pkg::SIZE_W-1:0] ar_size_i,
	input wire                       r_valid_i,
	input wire                       r_ready_i,
	input wire                       r_last_i,
	input wire                       cpu_r_valid_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [axi_pkg::LEN_W-1:0] beat_no;  // Beats seen in current burst

	always_ff @(posedge clk) begin
		if (!reset_n)
			beat_no <= '0;
		else if (r_valid_i && r_ready_i)
			beat_no <= r_last_i ? '0 : beat_no + 1'b1;
	end

	ar_stable: assert property (@(posedge clk) disable iff (!reset_n)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_id_i) && $stable(ar_addr_i)
			&& $stable(ar_len_i) && $stable(ar_size_i))
		else $error("AR valid or payload changed before ar_ready");

	r_last_on_len: assert property (@(posedge clk) disable iff (!reset_n)
		r_valid_i && r_ready_i |-> (r_last_i == (beat_no == ar_len_i)))
		else $error("r_last not on the beat numbered len");

	cpu_valid_reset: assert property (@(posedge clk) !reset_n |=> !cpu_r_valid_i)
		else $error("cpu_r_valid_o high after reset");

endmodule

`default_nettype wire

// File: bench/axi_read_tb.sv
`default_nettype none

module axi_read_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_W    = 32;
	localparam int MEM_AW    = 10;
	localparam int RESP_WAIT = 2;
	localparam int MEM_WORDS = 1 << MEM_AW;
	localparam int NUM_RAND  = 40;
	localparam int MAX_BEATS = 1 + 21 + 36 + 14 + NUM_RAND * 8;
	localparam int TIMEOUT   = MAX_BEATS * (RESP_WAIT + 4) + MEM_WORDS + 10 + 500;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
		logic [3:0]  id;
		logic        last;
		int          edge_no;  // Edge at which the core takes the beat
	} beat_t;

	logic                       clk;
	logic                       reset_n;
	logic                       req_valid;
	logic [3:0]                 req_id;
	logic [ADDR_W-1:0]          req_addr;
	logic [7:0]                 req_len;
	axi_pkg::access_size_e      req_size;
	logic                       mem_we;
	logic [MEM_AW-1:0]          mem_waddr;
	logic [63:0]                mem_wdata;
	logic                       cpu_req_ready;
	logic                       cpu_r_valid;
	logic [63:0]                cpu_r_data;
	axi_pkg::resp_e             cpu_r_resp;
	logic [3:0]                 cpu_r_id;
	logic                       cpu_r_last;

	logic [63:0] shadow [0:MEM_WORDS-1];
	beat_t       exp_q[$];
	int          cyc = 0;
	int          err_cnt = 0;
	int          beats_seen = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          err_mark = 0;
	int          beat_mark = 0;
	integer      seed;

	clock_gen clock_gen_inst (.clk_o(clk));

	axi_read_top #(
		.ADDR_W    (ADDR_W),
		.MEM_AW    (MEM_AW),
		.RESP_WAIT (RESP_WAIT)
	) axi_read_top_inst (
		.clk             (clk),
		.reset_n         (reset_n),
		.cpu_req_valid_i (req_valid),
		.cpu_req_ready_o (cpu_req_ready),
		.cpu_id_i        (req_id),
		.cpu_addr_i      (req_addr),
		.cpu_len_i       (req_len),
		.cpu_size_i      (req_size),
		.cpu_r_valid_o   (cpu_r_valid),
		.cpu_r_data_o    (cpu_r_data),
		.cpu_r_resp_o    (cpu_r_resp),
		.cpu_r_id_o      (cpu_r_id),
		.cpu_r_last_o    (cpu_r_last),
		.mem_we_i        (mem_we),
		.mem_waddr_i     (mem_waddr),
		.mem_wdata_i     (mem_wdata)
	);

	bind axi_read_master axi_read_props #(.ADDR_W(ADDR_W)) axi_read_props_inst (
		.clk           (clk),
		.reset_n       (reset_n),
		.ar_valid_i    (axi.ar_valid),
		.ar_ready_i    (axi.ar_ready),
		.ar_id_i       (axi.ar_id),
		.ar_addr_i     (axi.ar_addr),
		.ar_len_i      (axi.ar_len),
		.ar_size_i     (axi.ar_size),
		.r_valid_i     (axi.r_valid),
		.r_ready_i     (axi.r_ready),
		.r_last_i      (axi.r_last),
		.cpu_r_valid_i (cpu_r_valid_o)
	);

	always @(posedge clk) cyc <= cyc + 1;

	// Expected beat k of a request, from the shadow copy
	function automatic beat_t expected_beat(input logic [31:0] addr, input logic [1:0] size,
			input logic [7:0] len, input logic [3:0] id, input int k);
		beat_t       b;
		logic [28:0] word;
		int          off;
		int          nbytes;
		b = '0;
		word = addr[31:3] + 29'(k);
		off = int'(addr[2:0]);
		nbytes = 1 << size;
		b.id = id;
		b.last = (k == int'(len));
		if (word < 29'(MEM_WORDS)) begin
			b.resp = axi_pkg::OKAY;
			for (int i = 0; i < 8; i++)
				if (i >= off && i < off + nbytes)
					b.data[i*8 +: 8] = shadow[word[MEM_AW-1:0]][i*8 +: 8];
		end else begin
			b.resp = axi_pkg::SLVERR;  // Past the last word
		end
		return b;
	endfunction

	task automatic fill_memory();
		logic [63:0] word;
		for (int i = 0; i < MEM_WORDS; i++) begin
			word = {32'(i), ~32'(i)} ^ {$random(seed), $random(seed)};
			shadow[i] = word;
			@(posedge clk);
			mem_we    <= 1'b1;
			mem_waddr <= MEM_AW'(i);
			mem_wdata <= word;
		end
		@(posedge clk);
		mem_we <= 1'b0;
	endtask

	// Queues the expected beats and returns at the accepting edge
	task automatic issue_read(input logic [3:0] id, input logic [31:0] addr,
			input logic [7:0] len, input logic [1:0] size);
		int    accept_edge;
		beat_t b;
		@(posedge clk);
		req_valid <= 1'b1;
		req_id    <= id;
		req_addr  <= addr;
		req_len   <= len;
		req_size  <= axi_pkg::access_size_e'(size);
		@(negedge clk);
		while (!cpu_req_ready)
			@(negedge clk);
		accept_edge = cyc + 1;
		for (int k = 0; k <= int'(len); k++) begin
			b = expected_beat(addr, size, len, id, k);
			b.edge_no = accept_edge + RESP_WAIT + 3 + k;
			exp_q.push_back(b);
		end
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic report_test(input string name);
		int errs;
		while (exp_q.size() != 0)
			@(negedge clk);
		errs = err_cnt - err_mark;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("Test %0d %-22s %0d beats, %0d errors", tests_run, name,
			beats_seen - beat_mark, errs);
		err_mark = err_cnt;
		beat_mark = beats_seen;
	endtask

	initial begin : compare_beats
		beat_t b;
		forever begin
			@(negedge clk);
			if (cpu_r_valid === 1'b1) begin
				assert (exp_q.size() != 0) else begin
					$display("Core beat returned at %0t with no read outstanding", $time);
					err_cnt++;
				end
				if (exp_q.size() != 0) begin
					b = exp_q.pop_front();
					beats_seen++;
					assert (cpu_r_data == b.data) else begin
						$display("** Error at %0t: data %h, expected %h", $time, cpu_r_data, b.data);
						err_cnt++;
					end
					assert (cpu_r_resp == b.resp && cpu_r_id == b.id && cpu_r_last == b.last)
					else begin
						$display("** Error at %0t: resp/id/last %0d/%h/%b, expected %0d/%h/%b",
							$time, cpu_r_resp, cpu_r_id, cpu_r_last, b.resp, b.id, b.last);
						err_cnt++;
					end
					assert (cyc + 1 == b.edge_no) else begin
						$display("** Error at %0t: beat at edge %0d, expected edge %0d",
							$time, cyc + 1, b.edge_no);
						err_cnt++;
					end
				end
			end
		end
	end

	initial begin : watchdog
		while (cyc < TIMEOUT)
			@(posedge clk);
		$display("Timeout after %0d cycles, reads did not complete", cyc);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : main
		logic [31:0] rnd;
		int          n;
		seed = 32'ha868;
		reset_n   = 1'b0;
		req_valid = 1'b0;
		req_id    = '0;
		req_addr  = '0;
		req_len   = '0;
		req_size  = axi_pkg::BYTE8;
		mem_we    = 1'b0;
		mem_waddr = '0;
		mem_wdata = '0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		assert (cpu_req_ready === 1'b1 && cpu_r_valid === 1'b0) else begin
			$display("** Error at %0t: ready %b valid %b after reset", $time,
				cpu_req_ready, cpu_r_valid);
			err_cnt++;
		end
		fill_memory();

		issue_read(4'h9, 32'd42 * 8, 8'd0, 2'd3);
		report_test("single_aligned");

		n = 0;
		for (int sz = 0; sz < 4; sz++)
			for (int off = 0; off + (1 << sz) <= 8; off++) begin
				issue_read(4'(n), 32'((100 + n) * 8 + off), 8'd0, 2'(sz));
				n++;
			end
		report_test("narrow_lanes");

		for (int len = 1; len <= 8; len++)
			issue_read(4'(len), 32'((200 + len * 16) * 8), 8'(len - 1), 2'd3);
		report_test("incr_bursts");

		issue_read(4'h3, 32'(MEM_WORDS * 8), 8'd0, 2'd3);
		issue_read(4'h5, 32'((MEM_WORDS - 3) * 8 + 2), 8'd7, 2'd2);  // Crosses the end
		issue_read(4'h6, 32'((MEM_WORDS - 1) * 8), 8'd0, 2'd3);
		issue_read(4'h7, 32'h8000_0000, 8'd3, 2'd3);
		report_test("past_end");

		for (int i = 0; i < NUM_RAND; i++) begin
			rnd = $random(seed);
			issue_read(rnd[3:0], $random(seed) & 32'h0000_1fff, {5'b0, rnd[8:6]}, rnd[5:4]);
		end
		report_test("random_back_to_back");

		$display("Tests: %0d run, %0d failed; beats checked: %0d; errors: %0d",
			tests_run, tests_failed, beats_seen, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
logic/axi_pkg.sv
logic/axi_read_if.sv
logic/axi_read_master.sv
logic/axi_read_ram.sv
logic/axi_read_top.sv
bench/clock_gen.sv
bench/axi_read_props.sv
bench/axi_read_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=axi_read_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module axi_read_tb \
	--Mdir "$OBJ" -o "$EXE"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation run returned status $run_status"
	exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
